/* narrator_top.f */
source/narrator_pkg.sv
source/phoneme_table.sv
source/sample_rate_gen.sv
source/playback_ctrl.sv
source/flash_fetch.sv
source/intensity_meter.sv
source/narrator_top.sv
tb/narrator_assert.sv
tb/narrator_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the narrator testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module narrator_tb -f narrator_top.f -o narrator_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Build failed"
	exit 1
fi

./obj_dir/narrator_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Something failed" "$LOG"; then
	echo "Test failed"
	exit 1
fi
echo "Test passed"
exit 0

/* source/flash_fetch.sv */
module flash_fetch (
	input  logic                                 CLK_50M,
	input  logic                                 arst_n,
	input  logic                                 fetch_req,
	input  logic [narrator_pkg::BYTE_ADDR_W-1:0] fetch_addr,
	input  logic                                 fetch_silent,
	output logic                                 flash_read,
	output logic [narrator_pkg::WORD_ADDR_W-1:0] flash_addr,
	input  logic                                 flash_waitrequest,
	input  narrator_pkg::flash_word_t            flash_readdata,
	output logic [narrator_pkg::SAMPLE_W-1:0]    sample,
	output logic                                 sample_valid
);
	import narrator_pkg::*;

	// Byte lane of the pending read
	logic [1:0] lane_sel;
	// Silent fetch waits one cycle to match the flash latency
	logic       silent_pend;
	logic       read_end;

	// Read completes in the first cycle without waitrequest
	assign read_end = flash_read && !flash_waitrequest;

	// ==========================================================
	// Read master
	// ==========================================================

	always_ff @(posedge CLK_50M or negedge arst_n)
	begin
		if (!arst_n)
		begin
			flash_read   <= 1'b0;
			silent_pend  <= 1'b0;
			sample_valid <= 1'b0;
			sample       <= '0;
		end
		else
		begin
			sample_valid <= 1'b0;
			silent_pend  <= 1'b0;
			if (fetch_req && fetch_silent)
				silent_pend <= 1'b1;
			else if (fetch_req)
				flash_read <= 1'b1;
			if (read_end)
			begin
				flash_read   <= 1'b0;
				sample_valid <= 1'b1;
				sample       <= flash_readdata.lanes[lane_sel];
			end
			else if (silent_pend)
			begin
				sample_valid <= 1'b1;
				sample       <= '0;
			end
		end
	end

	// Address held steady for the whole read
	always_ff @(posedge CLK_50M)
	begin
		if (fetch_req && !fetch_silent)
		begin
			flash_addr <= fetch_addr[BYTE_ADDR_W-1:2];
			lane_sel   <= fetch_addr[1:0];
		end
	end

endmodule

/* source/intensity_meter.sv */
module intensity_meter (
	input  logic                              CLK_50M,
	input  logic                              arst_n,
	input  logic [narrator_pkg::SAMPLE_W-1:0] sample,
	input  logic                              sample_valid,
	output logic [7:0]                        intensity
);
	import narrator_pkg::*;

	// Magnitude fits one bit less than the sample
	logic [SAMPLE_W-2:0]            mag;
	logic [SAMPLE_W+METER_LOG2-2:0] acc;
	logic [SAMPLE_W+METER_LOG2-2:0] win_sum;
	logic [METER_LOG2-1:0]          win_cnt;

	// Absolute value of a signed byte
	always_comb
	begin
		if (!sample[SAMPLE_W-1])
			mag = sample[SAMPLE_W-2:0];
		else if (sample[SAMPLE_W-2:0] == '0)
			mag = '1;  // most negative value clipped to 127
		else
			mag = (~sample[SAMPLE_W-2:0]) + 1'b1;
	end

	assign win_sum = acc + mag;

	// Window of 256 samples, then average and restart
	always_ff @(posedge CLK_50M or negedge arst_n)
	begin
		if (!arst_n)
		begin
			acc       <= '0;
			win_cnt   <= '0;
			intensity <= '0;
		end
		else if (sample_valid)
		begin
			win_cnt <= win_cnt + 1'b1;
			if (&win_cnt)
			begin
				intensity <= 8'(win_sum >> METER_LOG2);
				acc       <= '0;
			end
			else
				acc <= win_sum;
		end
	end

endmodule

/* source/narrator_pkg.sv */
package narrator_pkg;

	// ==========================================================
	// Widths
	// ==========================================================

	// One audio byte per sample
	localparam int SAMPLE_W    = 8;
	// Flash byte address, word address drops the two lane bits
	localparam int BYTE_ADDR_W = 24;
	localparam int WORD_ADDR_W = BYTE_ADDR_W - 2;
	// Phoneme code from the sequencer
	localparam int PHONEME_W   = 8;
	localparam int DIV_W       = 16;

	// ==========================================================
	// Sample rate divisor
	// ==========================================================

	// About 14.4 kHz from 50 MHz
	localparam logic [DIV_W-1:0] DIV_DEFAULT = 16'd3472;
	localparam logic [DIV_W-1:0] DIV_STEP    = 16'd2;
	localparam logic [DIV_W-1:0] DIV_MIN     = 16'd64;
	localparam logic [DIV_W-1:0] DIV_MAX     = 16'd65534;

	// Meter window of 2**8 samples
	localparam int METER_LOG2 = 8;

	// Playback FSM state codes
	localparam logic [1:0] PB_IDLE      = 2'd0;
	localparam logic [1:0] PB_WAIT_TICK = 2'd1;
	localparam logic [1:0] PB_FETCH     = 2'd2;
	localparam logic [1:0] PB_FINISH    = 2'd3;

	// Flash data word, raw or split into byte lanes
	// Lane 0 sits in bits 7:0
	typedef union packed {
		logic [31:0]                  raw;
		logic [3:0][SAMPLE_W-1:0]     lanes;
	} flash_word_t;

endpackage

/* source/narrator_top.sv */
module narrator_top (
	input  logic                                 CLK_50M,
	input  logic                                 arst_n,
	// Sequencer side
	input  logic [narrator_pkg::PHONEME_W-1:0]   phoneme_sel,
	input  logic                                 phoneme_start,
	output logic                                 phoneme_done,
	// Speed control
	input  logic                                 speed_up,
	input  logic                                 speed_down,
	input  logic                                 speed_reset,
	output logic [narrator_pkg::DIV_W-1:0]       div_value,
	// Flash read port
	output logic                                 flash_read,
	output logic [narrator_pkg::WORD_ADDR_W-1:0] flash_addr,
	input  logic                                 flash_waitrequest,
	input  narrator_pkg::flash_word_t            flash_readdata,
	// Audio out and level
	output logic [narrator_pkg::SAMPLE_W-1:0]    sample,
	output logic                                 sample_valid,
	output logic [7:0]                           intensity
);
	import narrator_pkg::*;

	logic [BYTE_ADDR_W-1:0] start_addr;
	logic [BYTE_ADDR_W-1:0] end_addr;
	logic                   silent;
	logic                   sample_tick;
	logic                   fetch_req;
	logic [BYTE_ADDR_W-1:0] fetch_addr;
	logic                   fetch_silent;

	// Phoneme bounds lookup
	phoneme_table u_table (
		.CLK_50M     (CLK_50M),
		.arst_n      (arst_n),
		.phoneme_sel (phoneme_sel),
		.start_addr  (start_addr),
		.end_addr    (end_addr),
		.silent      (silent)
	);

	// Sample tick source
	sample_rate_gen u_rate (
		.CLK_50M     (CLK_50M),
		.arst_n      (arst_n),
		.speed_up    (speed_up),
		.speed_down  (speed_down),
		.speed_reset (speed_reset),
		.div_value   (div_value),
		.sample_tick (sample_tick)
	);

	// Address stepping and done
	playback_ctrl u_ctrl (
		.CLK_50M       (CLK_50M),
		.arst_n        (arst_n),
		.phoneme_start (phoneme_start),
		.start_addr    (start_addr),
		.end_addr      (end_addr),
		.silent        (silent),
		.sample_tick   (sample_tick),
		.sample_valid  (sample_valid),
		.phoneme_done  (phoneme_done),
		.fetch_req     (fetch_req),
		.fetch_addr    (fetch_addr),
		.fetch_silent  (fetch_silent)
	);

	// Flash reads and lane pick
	flash_fetch u_fetch (
		.CLK_50M           (CLK_50M),
		.arst_n            (arst_n),
		.fetch_req         (fetch_req),
		.fetch_addr        (fetch_addr),
		.fetch_silent      (fetch_silent),
		.flash_read        (flash_read),
		.flash_addr        (flash_addr),
		.flash_waitrequest (flash_waitrequest),
		.flash_readdata    (flash_readdata),
		.sample            (sample),
		.sample_valid      (sample_valid)
	);

	// LED level meter
	intensity_meter u_meter (
		.CLK_50M      (CLK_50M),
		.arst_n       (arst_n),
		.sample       (sample),
		.sample_valid (sample_valid),
		.intensity    (intensity)
	);

endmodule

/* source/phoneme_table.sv */
module phoneme_table (
	input  logic                                 CLK_50M,
	input  logic                                 arst_n,
	input  logic [narrator_pkg::PHONEME_W-1:0]   phoneme_sel,
	output logic [narrator_pkg::BYTE_ADDR_W-1:0] start_addr,
	output logic [narrator_pkg::BYTE_ADDR_W-1:0] end_addr,
	output logic                                 silent
);
	import narrator_pkg::*;

	logic [BYTE_ADDR_W-1:0] rom_start;
	logic [BYTE_ADDR_W-1:0] rom_end;

	// Bounds per phoneme, inclusive on both ends
	// Only the low three code bits select an entry
	always_comb
	begin
		case (phoneme_sel[2:0])
			// Silence, 24 bytes, never read from flash
			3'd0: {rom_start, rom_end} = {24'h000000, 24'h000017};
			// 13 bytes
			3'd1: {rom_start, rom_end} = {24'h000101, 24'h00010D};
			// 61 bytes
			3'd2: {rom_start, rom_end} = {24'h000223, 24'h00025F};
			// 31 bytes
			3'd3: {rom_start, rom_end} = {24'h000402, 24'h000420};
			// 36 bytes
			3'd4: {rom_start, rom_end} = {24'h000617, 24'h00063A};
			// 37 bytes
			3'd5: {rom_start, rom_end} = {24'h000805, 24'h000829};
			// 31 bytes
			3'd6: {rom_start, rom_end} = {24'h000A0E, 24'h000A2C};
			// 29 bytes
			default: {rom_start, rom_end} = {24'h000C33, 24'h000C4F};
		endcase
	end

	// Registered lookup, valid one cycle after phoneme_sel moves
	always_ff @(posedge CLK_50M or negedge arst_n)
	begin
		if (!arst_n)
		begin
			start_addr <= '0;
			end_addr   <= '0;
			silent     <= 1'b0;
		end
		else
		begin
			start_addr <= rom_start;
			end_addr   <= rom_end;
			silent     <= (phoneme_sel[2:0] == 3'd0);
		end
	end

endmodule

/* source/playback_ctrl.sv */
module playback_ctrl (
	input  logic                                 CLK_50M,
	input  logic                                 arst_n,
	input  logic                                 phoneme_start,
	input  logic [narrator_pkg::BYTE_ADDR_W-1:0] start_addr,
	input  logic [narrator_pkg::BYTE_ADDR_W-1:0] end_addr,
	input  logic                                 silent,
	input  logic                                 sample_tick,
	input  logic                                 sample_valid,
	output logic                                 phoneme_done,
	output logic                                 fetch_req,
	output logic [narrator_pkg::BYTE_ADDR_W-1:0] fetch_addr,
	output logic                                 fetch_silent
);
	import narrator_pkg::*;

	logic [1:0]             state;
	// Current byte and latched bounds of the running phoneme
	logic [BYTE_ADDR_W-1:0] cur_addr;
	logic [BYTE_ADDR_W-1:0] end_q;
	logic                   silent_q;
	logic                   start_ok;
	logic                   at_end;

	// Done while idle or in the one cycle tail after the last byte
	assign phoneme_done = (state == PB_IDLE) || (state == PB_FINISH);
	// Starts while busy are dropped here
	assign start_ok     = phoneme_start && phoneme_done;
	assign at_end       = (cur_addr == end_q);

	// Request goes out in the tick cycle itself
	// Ticks outside WAIT_TICK are lost on purpose
	assign fetch_req    = (state == PB_WAIT_TICK) && sample_tick;
	assign fetch_addr   = cur_addr;
	assign fetch_silent = silent_q;

	// ==========================================================
	// Control FSM
	// ==========================================================

	always_ff @(posedge CLK_50M or negedge arst_n)
	begin
		if (!arst_n)
			state <= PB_IDLE;
		else
		begin
			case (state)
				PB_IDLE, PB_FINISH:
				begin
					if (start_ok)
						state <= PB_WAIT_TICK;
					else
						state <= PB_IDLE;
				end
				PB_WAIT_TICK:
				begin
					if (sample_tick)
						state <= PB_FETCH;
				end
				PB_FETCH:
				begin
					// End test only on the sample of the last byte
					if (sample_valid)
						state <= at_end ? PB_FINISH : PB_WAIT_TICK;
				end
				default:
					state <= PB_IDLE;
			endcase
		end
	end

	// Bounds captured on an accepted start
	// Address steps once each fetch has returned
	always_ff @(posedge CLK_50M or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cur_addr <= '0;
			end_q    <= '0;
			silent_q <= 1'b0;
		end
		else if (start_ok)
		begin
			cur_addr <= start_addr;
			end_q    <= end_addr;
			silent_q <= silent;
		end
		else if ((state == PB_FETCH) && sample_valid && !at_end)
			cur_addr <= cur_addr + 1'b1;
	end

endmodule

/* source/sample_rate_gen.sv */
module sample_rate_gen (
	input  logic                           CLK_50M,
	input  logic                           arst_n,
	input  logic                           speed_up,
	input  logic                           speed_down,
	input  logic                           speed_reset,
	output logic [narrator_pkg::DIV_W-1:0] div_value,
	output logic                           sample_tick
);
	import narrator_pkg::*;

	logic [DIV_W-1:0] tick_cnt;

	// ==========================================================
	// Divisor register
	// ==========================================================

	// Reset level wins over up/down pulses
	// Steps clamp at both limits
	always_ff @(posedge CLK_50M or negedge arst_n)
	begin
		if (!arst_n)
			div_value <= DIV_DEFAULT;
		else if (speed_reset)
			div_value <= DIV_DEFAULT;
		else if (speed_up)
		begin
			if (div_value >= DIV_MAX - DIV_STEP)
				div_value <= DIV_MAX;
			else
				div_value <= div_value + DIV_STEP;
		end
		else if (speed_down)
		begin
			if (div_value <= DIV_MIN + DIV_STEP)
				div_value <= DIV_MIN;
			else
				div_value <= div_value - DIV_STEP;
		end
	end

	// ==========================================================
	// Tick counter
	// ==========================================================

	// Down count to zero then reload, one tick per div_value cycles
	// A new divisor takes effect at the next reload
	always_ff @(posedge CLK_50M or negedge arst_n)
	begin
		if (!arst_n)
		begin
			tick_cnt    <= DIV_DEFAULT - 1'b1;
			sample_tick <= 1'b0;
		end
		else if (tick_cnt == '0)
		begin
			tick_cnt    <= div_value - 1'b1;
			sample_tick <= 1'b1;
		end
		else
		begin
			tick_cnt    <= tick_cnt - 1'b1;
			sample_tick <= 1'b0;
		end
	end

endmodule

/* tb/narrator_assert.sv */
module playback_checks (
	input logic                                 CLK_50M,
	input logic                                 arst_n,
	input logic                                 phoneme_start,
	input logic                                 sample_valid,
	input logic                                 phoneme_done,
	input logic                                 fetch_req,
	input logic [narrator_pkg::BYTE_ADDR_W-1:0] fetch_addr
);
	timeunit 1ns;
	timeprecision 100ps;

	// Set by a request and cleared by its sample
	logic pending;

	always_ff @(posedge CLK_50M or negedge arst_n)
	begin
		if (!arst_n)
			pending <= 1'b0;
		else if (fetch_req)
			pending <= 1'b1;
		else if (sample_valid)
			pending <= 1'b0;
	end

	// ==========================================================
	// Control checks
	// ==========================================================

	no_double_fetch: assert property (@(posedge CLK_50M) disable iff (!arst_n)
		fetch_req |-> !pending)
		else $error("fetch_req raised while a fetch is outstanding");

	done_after_reset: assert property (@(posedge CLK_50M)
		!arst_n |=> phoneme_done)
		else $error("phoneme_done low after reset");

	// Address may still step on a returning sample
	busy_start_ignored: assert property (@(posedge CLK_50M) disable iff (!arst_n)
		phoneme_start && !phoneme_done && !sample_valid |=> $stable(fetch_addr))
		else $error("start while busy moved fetch_addr");

endmodule

bind playback_ctrl playback_checks u_checks (.*);

/* tb/narrator_input.txt */
# cmd  arg1  arg2  arg3
# U n and D n pulse the divisor up or down n times, R resets it
# E div checks div_value, M level checks intensity
# P code count start plays a code and expects count bytes from hex start
E 3472
U 5
E 3482
D 8
E 3466
R
E 3472
D 1720
E 64
D 3
E 64
P 1 13 101
P 0 24 0
P 2 61 223
P 3 31 402
U 3
E 70
P 4 36 617
P 5 37 805
P 6 31 a0e
P 7 29 c33
P 2 61 223

/* tb/narrator_tb.sv */
module narrator_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import narrator_pkg::*;

	localparam logic [31:0] SEED = 32'hd6c8_498e;
	// Longest divisor plus a reload after a divisor change
	localparam int WAIT_LIMIT = 150000;

	logic                   CLK_50M;
	logic                   arst_n;
	logic [PHONEME_W-1:0]   phoneme_sel;
	logic                   phoneme_start;
	logic                   phoneme_done;
	logic                   speed_up;
	logic                   speed_down;
	logic                   speed_reset;
	logic [DIV_W-1:0]       div_value;
	logic                   flash_read;
	logic [WORD_ADDR_W-1:0] flash_addr;
	logic                   flash_waitrequest = 1'b1;
	flash_word_t            flash_readdata = '0;
	logic [SAMPLE_W-1:0]    sample;
	logic                   sample_valid;
	logic [7:0]             intensity;

	// Flash model state
	logic [31:0]            rng = SEED;
	logic                   read_busy = 1'b0;
	int                     wait_left = 0;
	logic [WORD_ADDR_W-1:0] read_addr = '0;
	int                     read_count = 0;

	// Reference meter
	int                     meter_acc = 0;
	int                     meter_cnt = 0;
	logic [7:0]             exp_intensity = 8'h00;

	narrator_top uut (.*);

	always #10 CLK_50M = ~CLK_50M;

	// ==========================================================
	// Reference rules
	// ==========================================================

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Flash content is one LCG step from the word address
	function automatic logic [31:0] flash_word(input logic [WORD_ADDR_W-1:0] a);
		return lcg_next({10'd0, a} ^ SEED);
	endfunction

	function automatic logic [SAMPLE_W-1:0] flash_byte(input logic [BYTE_ADDR_W-1:0] a);
		flash_word_t w;
		w.raw = flash_word(a[BYTE_ADDR_W-1:2]);
		return w.lanes[a[1:0]];
	endfunction

	// Signed magnitude with -128 clipped to 127
	function automatic int magnitude(input logic [7:0] b);
		if (b == 8'h80)
			return 127;
		else if (b[7])
			return 256 - int'(b);
		else
			return int'(b);
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		$display("FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
		$display("Something failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic report_error(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		$display("Something failed");
		$fatal(1, "stopping at first error");
	endtask

	// Window of 256 samples then average
	task automatic meter_update(input logic [7:0] b);
		meter_acc = meter_acc + magnitude(b);
		meter_cnt = meter_cnt + 1;
		if (meter_cnt == 256)
		begin
			exp_intensity = 8'(meter_acc >> 8);
			meter_acc     = 0;
			meter_cnt     = 0;
		end
	endtask

	// ==========================================================
	// Flash model
	// ==========================================================

	// Answers each read after 0 to 3 wait cycles
	always @(negedge CLK_50M)
	begin
		if (!flash_read)
		begin
			read_busy          = 1'b0;
			flash_waitrequest  = 1'b1;
			flash_readdata.raw = '0;
		end
		else
		begin
			if (!read_busy)
			begin
				read_busy  = 1'b1;
				read_addr  = flash_addr;
				read_count = read_count + 1;
				rng        = lcg_next(rng);
				wait_left  = int'(rng[17:16]);
			end
			else
			begin
				// Address must hold for the whole read
				assert (flash_addr == read_addr)
				else report_mismatch("flash_addr", 32'(flash_addr), 32'(read_addr));
				if (wait_left > 0)
					wait_left = wait_left - 1;
			end
			flash_waitrequest  = (wait_left != 0);
			flash_readdata.raw = (wait_left == 0) ? flash_word(read_addr) : 32'h0;
		end
	end

	// ==========================================================
	// Stimulus tasks
	// ==========================================================

	task automatic wait_sample();
		int cycles;
		cycles = 0;
		do
		begin
			@(negedge CLK_50M);
			cycles = cycles + 1;
			if (cycles > WAIT_LIMIT)
				report_error("no sample_valid within the timeout");
		end
		while (!sample_valid);
	endtask

	// Single cycle pulses with a one cycle gap
	task automatic pulse_speed(input logic up, input int n);
		for (int i = 0; i < n; i++)
		begin
			@(negedge CLK_50M);
			speed_up   = up;
			speed_down = !up;
			@(negedge CLK_50M);
			speed_up   = 1'b0;
			speed_down = 1'b0;
		end
	endtask

	task automatic reset_speed();
		@(negedge CLK_50M);
		speed_reset = 1'b1;
		@(negedge CLK_50M);
		speed_reset = 1'b0;
	endtask

	task automatic play(input int code, input int count, input logic [BYTE_ADDR_W-1:0] start);
		logic [BYTE_ADDR_W-1:0] addr;
		logic [SAMPLE_W-1:0]    exp_byte;
		int                     reads_before;
		int                     reads_expected;
		logic                   silent;
		silent = (code[2:0] == 3'd0);
		assert (phoneme_done) else report_error("phoneme_done low before a start");
		@(negedge CLK_50M);
		phoneme_sel = PHONEME_W'(code);
		// Table output settles before start
		repeat (2) @(negedge CLK_50M);
		phoneme_start = 1'b1;
		reads_before  = read_count;
		@(negedge CLK_50M);
		phoneme_start = 1'b0;
		assert (!phoneme_done) else report_error("phoneme_done still high after start");
		for (int i = 0; i < count; i++)
		begin
			wait_sample();
			addr     = start + BYTE_ADDR_W'(i);
			exp_byte = silent ? 8'h00 : flash_byte(addr);
			assert (sample == exp_byte)
			else report_mismatch("sample", 32'(sample), 32'(exp_byte));
			assert (!phoneme_done)
			else report_error("phoneme_done high before the last sample");
			meter_update(exp_byte);
			// Start with another code while busy
			// Its bounds reach the table output first
			if (i == 0)
			begin
				phoneme_sel = PHONEME_W'(code ^ 5);
				repeat (2) @(negedge CLK_50M);
				phoneme_start = 1'b1;
				@(negedge CLK_50M);
				phoneme_start = 1'b0;
				phoneme_sel   = PHONEME_W'(code);
			end
		end
		@(negedge CLK_50M);
		assert (phoneme_done) else report_error("phoneme_done not high after the last sample");
		// One read per byte and none for silence
		reads_expected = silent ? reads_before : reads_before + count;
		assert (read_count == reads_expected)
		else report_mismatch("flash read count", 32'(read_count), 32'(reads_expected));
		assert (intensity == exp_intensity)
		else report_mismatch("intensity", 32'(intensity), 32'(exp_intensity));
	endtask

	// ==========================================================
	// Command player
	// ==========================================================

	initial
	begin
		int          fd;
		int          n;
		int          a;
		int          b;
		logic [31:0] c;
		string       line;
		string       cmd;
		CLK_50M       = 1'b0;
		arst_n        = 1'b0;
		phoneme_sel   = '0;
		phoneme_start = 1'b0;
		speed_up      = 1'b0;
		speed_down    = 1'b0;
		speed_reset   = 1'b0;
		repeat (10) @(negedge CLK_50M);
		arst_n = 1'b1;
		@(negedge CLK_50M);
		// Idle outputs after reset
		assert (phoneme_done) else report_error("phoneme_done low after reset");
		assert (!flash_read) else report_error("flash_read high after reset");
		assert (!sample_valid) else report_error("sample_valid high after reset");
		assert (sample == 8'h00) else report_mismatch("sample", 32'(sample), 32'h0);
		assert (intensity == 8'h00) else report_mismatch("intensity", 32'(intensity), 32'h0);
		assert (div_value == 16'd3472)
		else report_mismatch("div_value", 32'(div_value), 32'd3472);

		fd = $fopen("tb/narrator_input.txt", "r");
		if (fd == 0)
			report_error("cannot open tb/narrator_input.txt");
		while ($fgets(line, fd) != 0)
		begin
			if (line.len() < 2 || line[0] == "#")
				continue;
			n = $sscanf(line, "%s %d %d %h", cmd, a, b, c);
			if (cmd == "P")
			begin
				if (n != 4)
					report_error("play command needs code, count and start");
				play(a, b, c[BYTE_ADDR_W-1:0]);
			end
			else if (cmd == "U")
				pulse_speed(1'b1, a);
			else if (cmd == "D")
				pulse_speed(1'b0, a);
			else if (cmd == "R")
				reset_speed();
			else if (cmd == "E")
			begin
				@(negedge CLK_50M);
				assert (div_value == DIV_W'(a))
				else report_mismatch("div_value", 32'(div_value), 32'(a));
			end
			else if (cmd == "M")
			begin
				assert (intensity == 8'(a))
				else report_mismatch("intensity", 32'(intensity), 32'(a));
			end
			else
				report_error({"unknown command ", cmd});
		end
		$fclose(fd);
		$display("Everything OK");
		$finish;
	end

endmodule
